// File: src/sys_ctrl_defines.svh
/*
 * System control constants
 * Host command codes, bit positions inside the settings words
 * and the button debounce timing
 */

`ifndef SYS_CTRL_DEFINES_SVH
`define SYS_CTRL_DEFINES_SVH

// Host command codes, low byte of the first word
`define CMD_CFG 8'h01
`define CMD_LED 8'h25
`define CMD_VOL 8'h26

// Composite sync enable in the config word
`define CFG_CSYNC_BIT 3

// Mute flag of the volume attenuation
`define VOL_MUTE_BIT 4

// Cycles between button samples
// Short for fast simulation, hardware would use about 100000
`define DEBOUNCE_TICK 16

// Equal samples in a row before the button output changes
`define DEBOUNCE_LEN 8

`endif

// File: src/sys_ctrl_pkg.sv
/*
 * System control types
 * Vector types shared by the host decoder, the audio mixer
 * and the LED logic, plus the decoder state encoding
 */

package sys_ctrl_pkg;

	// Host port data word
	typedef logic [15:0] io_word_t;

	// Command code taken from the low byte
	typedef logic [7:0] cmd_t;

	// One audio sample, signed or unsigned
	typedef logic [15:0] sample_t;

	// Crossfeed amount, 0 is none and 3 is full mono
	typedef logic [1:0] mix_mode_t;

	// Bit 4 mutes, bits 3:0 give the right shift
	typedef logic [4:0] vol_att_t;

	// Main board LED byte
	typedef logic [7:0] led_vec_t;

	typedef enum logic {
		DEC_IDLE,
		DEC_DATA
	} dec_state_t;

endpackage

// File: src/sys_settings_if.sv
/*
 * Decoded settings bundle
 * Driven by the host command decoder, read by the audio mixer,
 * the VGA sync output and the LED status logic
 */

`timescale 1ns/100ps

interface sys_settings_if;
	import sys_ctrl_pkg::*;

	logic     csync;
	led_vec_t led_overtake;
	led_vec_t led_state;
	vol_att_t vol_att;

	modport decoder (
		output csync,
		output led_overtake,
		output led_state,
		output vol_att
	);

	modport user (
		input csync,
		input led_overtake,
		input led_state,
		input vol_att
	);

endinterface

// File: src/host_cmd_decoder.sv
/*
 * Host command decoder
 * Synchronizes the io_clk strobe, returns it as io_ack three stages
 * later, and turns command and data words into settings
 */

`timescale 1ns/100ps

`include "sys_ctrl_defines.svh"

module host_cmd_decoder (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  io_clk,
	input  logic                  io_uio,
	input  sys_ctrl_pkg::io_word_t io_din,
	output logic                  io_ack,
	sys_settings_if.decoder       settings
);
	import sys_ctrl_pkg::*;

	logic [2:0] clk_sr;
	logic       io_strobe;
	dec_state_t state;
	cmd_t       cmd;
	io_word_t   cfg_word;

	// ============================================================
	// Strobe synchronizer and acknowledge
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_sr <= '0;
		end else begin
			clk_sr <= {clk_sr[1:0], io_clk};
		end
	end

	// Rising edge after two sync stages
	assign io_strobe = clk_sr[1] & ~clk_sr[2];

	// Host waits for this to match io_clk
	assign io_ack = clk_sr[2];

	// ============================================================
	// Command FSM
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state                 <= DEC_IDLE;
			cfg_word              <= '0;
			settings.led_overtake <= '0;
			settings.led_state    <= '0;
			settings.vol_att      <= '0;
		end else if (!io_uio) begin
			state <= DEC_IDLE;
		end else if (io_strobe) begin
			case (state)
				DEC_IDLE: begin
					state <= DEC_DATA;
				end
				DEC_DATA: begin
					// Unknown codes fall through and drop the word
					case (cmd)
						`CMD_CFG: cfg_word <= io_din;
						`CMD_LED: begin
							settings.led_overtake <= io_din[15:8];
							settings.led_state    <= io_din[7:0];
						end
						`CMD_VOL: settings.vol_att <= io_din[4:0];
						default: ;
					endcase
				end
				default: state <= DEC_IDLE;
			endcase
		end
	end

	// Command byte of the current transfer
	always_ff @(posedge clk_sys) begin
		if (io_uio && io_strobe && state == DEC_IDLE) begin
			cmd <= io_din[7:0];
		end
	end

	assign settings.csync = cfg_word[`CFG_CSYNC_BIT];

endmodule

// File: src/button_debounce.sv
/*
 * Button debouncer
 * Samples an active-low button at a slow tick and changes the
 * output only after a full run of equal samples
 */

`timescale 1ns/100ps

`include "sys_ctrl_defines.svh"

module button_debounce (
	input  logic clk_sys,
	input  logic resetd,
	input  logic btn_n,
	output logic pressed
);

	localparam int TICK_W = $clog2(`DEBOUNCE_TICK);

	logic [TICK_W-1:0]        div_cnt;
	logic                     tick;
	logic [`DEBOUNCE_LEN-1:0] samples;

	assign tick = (div_cnt == TICK_W'(`DEBOUNCE_TICK - 1));

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			div_cnt <= '0;
			samples <= '0;
			pressed <= 1'b0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				samples <= {samples[`DEBOUNCE_LEN-2:0], ~btn_n};
				// Mixed history keeps the old state
				if (&samples) pressed <= 1'b1;
				if (~|samples) pressed <= 1'b0;
			end
		end
	end

endmodule

// File: src/audio_mixer.sv
/*
 * Stereo audio mixer
 * Stage 1 blends some of each channel into the other,
 * stage 2 applies the host volume shift or mute
 */

`timescale 1ns/100ps

`include "sys_ctrl_defines.svh"

module audio_mixer (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  sys_ctrl_pkg::sample_t   audio_l_in,
	input  sys_ctrl_pkg::sample_t   audio_r_in,
	input  logic                   audio_signed,
	input  sys_ctrl_pkg::mix_mode_t audio_mix,
	sys_settings_if.user           settings,
	output sys_ctrl_pkg::sample_t   audio_l,
	output sys_ctrl_pkg::sample_t   audio_r
);
	import sys_ctrl_pkg::*;

	sample_t mix_l;
	sample_t mix_r;
	logic    sgn_q;

	// Right shift, arithmetic for signed samples
	function automatic sample_t shr(input sample_t v, input logic [3:0] amt, input logic sgn);
		if (sgn) begin
			return sample_t'($signed(v) >>> amt);
		end
		return v >> amt;
	endfunction

	function automatic sample_t mix_ch(input sample_t own, input sample_t other,
			input mix_mode_t mode, input logic sgn);
		case (mode)
			2'd1:    return own - shr(own, 4'd3, sgn) + shr(other, 4'd3, sgn);
			2'd2:    return own - shr(own, 4'd2, sgn) + shr(other, 4'd2, sgn);
			2'd3:    return shr(own, 4'd1, sgn) + shr(other, 4'd1, sgn);
			default: return own;
		endcase
	endfunction

	// ============================================================
	// Stage 1, crossfeed
	// ============================================================

	always_ff @(posedge clk_sys) begin
		mix_l <= mix_ch(audio_l_in, audio_r_in, audio_mix, audio_signed);
		mix_r <= mix_ch(audio_r_in, audio_l_in, audio_mix, audio_signed);
		// Signedness travels with its sample
		sgn_q <= audio_signed;
	end

	// ============================================================
	// Stage 2, volume
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (resetd || settings.vol_att[`VOL_MUTE_BIT]) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= shr(mix_l, settings.vol_att[3:0], sgn_q);
			audio_r <= shr(mix_r, settings.vol_att[3:0], sgn_q);
		end
	end

endmodule

// File: src/sync_polarity_fix.sv
/*
 * Sync polarity normalizer
 * Measures the high and low phases of a sync signal and inverts
 * it when needed, so the short phase is always the high one
 */

`timescale 1ns/100ps

module sync_polarity_fix #(
	parameter int CNT_W = 16
) (
	input  logic clk_sys,
	input  logic resetd,
	input  logic sync_in,
	output logic sync_out
);

	logic             sync_q;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] high_len;
	logic [CNT_W-1:0] low_len;
	logic             pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_q   <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
			sync_out <= 1'b0;
		end else begin
			sync_q <= sync_in;
			if (sync_in != sync_q) begin
				cnt <= '0;
				// Count holds the length of the phase just ended
				if (sync_in) low_len <= cnt;
				else high_len <= cnt;
			end else if (cnt != '1) begin
				cnt <= cnt + 1'b1;
			end
			pol      <= high_len > low_len;
			sync_out <= sync_in ^ pol;
		end
	end

endmodule

// File: src/vga_sync_out.sv
/*
 * VGA sync output
 * Normalizes hsync and vsync and drives the active-low VGA pins,
 * either separate or as composite sync on the hsync pin
 */

`timescale 1ns/100ps

module vga_sync_out (
	input  logic          clk_sys,
	input  logic          resetd,
	input  logic          hs_in,
	input  logic          vs_in,
	sys_settings_if.user  settings,
	output logic          vga_hs,
	output logic          vga_vs
);

	logic hs_norm;
	logic vs_norm;

	sync_polarity_fix u_fix_h (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.sync_in  (hs_in),
		.sync_out (hs_norm)
	);

	sync_polarity_fix u_fix_v (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.sync_in  (vs_in),
		.sync_out (vs_norm)
	);

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
		end else if (settings.csync) begin
			vga_hs <= ~(hs_norm ^ vs_norm);
			vga_vs <= 1'b1;
		end else begin
			vga_hs <= ~hs_norm;
			vga_vs <= ~vs_norm;
		end
	end

endmodule

// File: src/led_status.sv
/*
 * Main board LED status
 * Builds the LED byte from the core's user, disk and power
 * requests, with per-bit override from the host
 */

`timescale 1ns/100ps

module led_status (
	input  logic                  clk_sys,
	input  logic                  resetd,
	input  logic                  core_led_user,
	input  logic [1:0]            core_led_power,
	input  logic [1:0]            core_led_disk,
	sys_settings_if.user          settings,
	output sys_ctrl_pkg::led_vec_t led
);
	import sys_ctrl_pkg::*;

	logic     power_on;
	led_vec_t led_dflt;

	// Power LED stays lit unless the core takes control of it
	assign power_on = core_led_power[1] ? core_led_power[0] : 1'b1;

	assign led_dflt = {3'b000, power_on, 1'b0, core_led_disk[0], 1'b0, core_led_user};

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			led <= '0;
		end else begin
			led <= (settings.led_overtake & settings.led_state) |
				(~settings.led_overtake & led_dflt);
		end
	end

endmodule

// File: src/sys_ctrl_top.sv
/*
 * System control top level
 * Host command port, button debounce, audio mixer, VGA sync and
 * LED status of the shell, all on clk_sys
 */

`timescale 1ns/100ps

module sys_ctrl_top (
	input  logic                   clk_sys,
	input  logic                   resetd,
	input  logic                   io_clk,
	input  logic                   io_uio,
	input  sys_ctrl_pkg::io_word_t  io_din,
	output logic                   io_ack,
	input  logic                   btn_user_n,
	input  logic                   btn_osd_n,
	output logic                   btn_user,
	output logic                   btn_osd,
	input  sys_ctrl_pkg::sample_t   audio_l_in,
	input  sys_ctrl_pkg::sample_t   audio_r_in,
	input  logic                   audio_signed,
	input  sys_ctrl_pkg::mix_mode_t audio_mix,
	output sys_ctrl_pkg::sample_t   audio_l,
	output sys_ctrl_pkg::sample_t   audio_r,
	input  logic                   hs_in,
	input  logic                   vs_in,
	output logic                   vga_hs,
	output logic                   vga_vs,
	input  logic                   core_led_user,
	input  logic [1:0]             core_led_power,
	input  logic [1:0]             core_led_disk,
	output sys_ctrl_pkg::led_vec_t  led
);

	sys_settings_if settings ();

	// ============================================================
	// Host side
	// ============================================================

	host_cmd_decoder u_decoder (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.io_clk   (io_clk),
		.io_uio   (io_uio),
		.io_din   (io_din),
		.io_ack   (io_ack),
		.settings (settings.decoder)
	);

	button_debounce u_deb_user (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.btn_n   (btn_user_n),
		.pressed (btn_user)
	);

	button_debounce u_deb_osd (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.btn_n   (btn_osd_n),
		.pressed (btn_osd)
	);

	// ============================================================
	// Core side outputs
	// ============================================================

	audio_mixer u_mixer (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.audio_l_in   (audio_l_in),
		.audio_r_in   (audio_r_in),
		.audio_signed (audio_signed),
		.audio_mix    (audio_mix),
		.settings     (settings.user),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	vga_sync_out u_vga_sync (
		.clk_sys  (clk_sys),
		.resetd   (resetd),
		.hs_in    (hs_in),
		.vs_in    (vs_in),
		.settings (settings.user),
		.vga_hs   (vga_hs),
		.vga_vs   (vga_vs)
	);

	led_status u_led (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.core_led_user  (core_led_user),
		.core_led_power (core_led_power),
		.core_led_disk  (core_led_disk),
		.settings       (settings.user),
		.led            (led)
	);

endmodule

// File: test/tb_sys_ctrl.sv
/*
 * System control testbench
 * Directed tests for the host port, LED status, audio mixer,
 * button debounce and VGA sync outputs
 */

`timescale 1ns/100ps

`include "sys_ctrl_defines.svh"

module tb_sys_ctrl;
	import sys_ctrl_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000;
	localparam int H_PERIOD = 14;
	localparam int H_SHORT  = 3;
	localparam int V_PERIOD = 40;
	localparam int V_SHORT  = 5;

	logic      clk_sys;
	logic      resetd;
	logic      io_clk;
	logic      io_uio;
	io_word_t  io_din;
	logic      io_ack;
	logic      btn_user_n;
	logic      btn_osd_n;
	logic      btn_user;
	logic      btn_osd;
	sample_t   audio_l_in;
	sample_t   audio_r_in;
	logic      audio_signed;
	mix_mode_t audio_mix;
	sample_t   audio_l;
	sample_t   audio_r;
	logic      hs_in;
	logic      vs_in;
	logic      vga_hs;
	logic      vga_vs;
	logic      core_led_user;
	logic [1:0] core_led_power;
	logic [1:0] core_led_disk;
	led_vec_t  led;

	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;
	logic [31:0] lfsr;

	// Sync generator state and the 2-cycle history of the active phase
	logic sync_en;
	logic h_inv;
	logic v_inv;
	int   h_cnt;
	int   v_cnt;
	logic h_d1;
	logic h_d2;
	logic v_d1;
	logic v_d2;
	logic exp_h;
	logic exp_v;

	sys_ctrl_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// ============================================================
	// Helpers
	// ============================================================

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// One clock step, inputs change 1 ns after the edge
	task automatic tick();
		logic act_h;
		logic act_v;
		@(posedge clk_sys);
		#1;
		exp_h = h_d2;
		exp_v = v_d2;
		if (sync_en) begin
			h_cnt = (h_cnt + 1) % H_PERIOD;
			v_cnt = (v_cnt + 1) % V_PERIOD;
		end
		act_h = sync_en && (h_cnt < H_SHORT);
		act_v = sync_en && (v_cnt < V_SHORT);
		hs_in = sync_en ? (act_h ^ h_inv) : 1'b0;
		vs_in = sync_en ? (act_v ^ v_inv) : 1'b0;
		h_d2 = h_d1;
		h_d1 = act_h;
		v_d2 = v_d1;
		v_d1 = act_v;
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		while (io_ack !== io_clk && n < 8) begin
			tick();
			n++;
		end
		checks++;
		assert (io_ack === io_clk) else begin
			errors++;
			$display("ERROR at %0t: io_ack did not follow io_clk within 8 cycles", $time);
		end
	endtask

	task automatic host_word(input io_word_t w);
		io_din = w;
		io_clk = 1'b1;
		wait_ack();
		io_clk = 1'b0;
		wait_ack();
	endtask

	task automatic host_write(input cmd_t cmd, input io_word_t d0, input io_word_t d1,
			input int n);
		io_uio = 1'b1;
		host_word({8'h00, cmd});
		host_word(d0);
		if (n > 1) host_word(d1);
		io_uio = 1'b0;
		tick();
	endtask

	function automatic led_vec_t led_default(input logic user, input logic [1:0] power,
			input logic [1:0] disk);
		led_vec_t d;
		d = '0;
		d[0] = user;
		d[2] = disk[0];
		d[4] = power[1] ? power[0] : 1'b1;
		return d;
	endfunction

	// Crossfeed, then volume shift or mute, in 32-bit integer math
	function automatic sample_t mix_expect(input sample_t own, input sample_t other,
			input mix_mode_t mode, input logic sgn, input vol_att_t att);
		int          o;
		int          t;
		int          m;
		logic [15:0] m16;
		o = sgn ? int'($signed(own)) : int'(own);
		t = sgn ? int'($signed(other)) : int'(other);
		case (mode)
			2'd0:    m = o;
			2'd1:    m = o - (o >>> 3) + (t >>> 3);
			2'd2:    m = o - (o >>> 2) + (t >>> 2);
			default: m = (o >>> 1) + (t >>> 1);
		endcase
		m16 = m[15:0];
		if (att[`VOL_MUTE_BIT]) return '0;
		m = sgn ? int'($signed(m16)) : int'(m16);
		return sample_t'(m >>> att[3:0]);
	endfunction

	// ============================================================
	// Tests
	// ============================================================

	task automatic test_reset();
		check_eq("io_ack", io_ack, 1'b0);
		check_eq("btn_user", btn_user, 1'b0);
		check_eq("btn_osd", btn_osd, 1'b0);
		check_eq("audio_l", audio_l, 16'h0);
		check_eq("audio_r", audio_r, 16'h0);
		check_eq("vga_hs", vga_hs, 1'b1);
		check_eq("vga_vs", vga_vs, 1'b1);
		check_eq("led", led, led_default(core_led_user, core_led_power, core_led_disk));
	endtask

	task automatic test_led();
		io_word_t d;
		led_vec_t dflt;
		led_vec_t exp;
		int       k;
		int       b;
		for (k = 0; k < 3; k++) begin
			core_led_user = 1'(rand_bits(1));
			core_led_power = 2'(rand_bits(2));
			core_led_disk = 2'(rand_bits(2));
			d = io_word_t'(rand_bits(16));
			// Second data word wins
			host_write(`CMD_LED, io_word_t'(rand_bits(16)), d, 2);
			repeat (6) tick();
			dflt = led_default(core_led_user, core_led_power, core_led_disk);
			// Overridden bits take the host state
			for (b = 0; b < 8; b++) begin
				exp[b] = d[8 + b] ? d[b] : dflt[b];
			end
			check_eq("led", led, exp);
		end
		// Unknown command leaves the last LED byte in place
		host_write(8'h77, io_word_t'(rand_bits(16)), io_word_t'(rand_bits(16)), 2);
		repeat (6) tick();
		check_eq("led", led, exp);
	endtask

	task automatic test_audio();
		vol_att_t vols [5] = '{5'd0, 5'd3, 5'd9, 5'h10, 5'h15};
		sample_t  q_l [$];
		sample_t  q_r [$];
		int       v;
		int       i;
		for (v = 0; v < 5; v++) begin
			host_write(`CMD_VOL, {11'd0, vols[v]}, 16'h0, 1);
			for (i = 0; i < 42; i++) begin
				tick();
				if (i >= 2) begin
					check_eq("audio_l", audio_l, q_l.pop_front());
					check_eq("audio_r", audio_r, q_r.pop_front());
				end
				if (i < 40) begin
					audio_l_in = sample_t'(rand_bits(16));
					audio_r_in = sample_t'(rand_bits(16));
					audio_mix = mix_mode_t'(rand_bits(2));
					audio_signed = 1'(rand_bits(1));
					q_l.push_back(mix_expect(audio_l_in, audio_r_in, audio_mix,
						audio_signed, vols[v]));
					q_r.push_back(mix_expect(audio_r_in, audio_l_in, audio_mix,
						audio_signed, vols[v]));
				end
			end
		end
	endtask

	task automatic drive_button(input int which, input logic level_n);
		if (which == 0) btn_user_n = level_n;
		else btn_osd_n = level_n;
	endtask

	function automatic logic button_out(input int which);
		return (which == 0) ? btn_user : btn_osd;
	endfunction

	task automatic test_buttons();
		string nm;
		int    w;
		int    i;
		for (w = 0; w < 2; w++) begin
			nm = (w == 0) ? "btn_user" : "btn_osd";
			drive_button(w, 1'b0);
			repeat (200) tick();
			check_eq(nm, button_out(w), 1'b1);
			check_eq((w == 0) ? "btn_osd" : "btn_user", button_out(1 - w), 1'b0);
			drive_button(w, 1'b1);
			repeat (200) tick();
			check_eq(nm, button_out(w), 1'b0);
			// Glitch shorter than one sample tick
			drive_button(w, 1'b0);
			for (i = 0; i < 70; i++) begin
				if (i == 10) drive_button(w, 1'b1);
				tick();
				check_eq(nm, button_out(w), 1'b0);
			end
		end
	endtask

	task automatic check_sync(input logic csync);
		logic e_hs;
		logic e_vs;
		e_hs = csync ? ~(exp_h ^ exp_v) : ~exp_h;
		e_vs = csync ? 1'b1 : ~exp_v;
		check_eq("vga_hs", vga_hs, e_hs);
		check_eq("vga_vs", vga_vs, e_vs);
	endtask

	task automatic sync_phase(input logic csync);
		repeat (2 * V_PERIOD + 4) tick();
		repeat (2 * V_PERIOD) begin
			tick();
			check_sync(csync);
		end
	endtask

	task automatic test_sync();
		sync_en = 1'b1;
		h_inv = 1'b0;
		v_inv = 1'b1;
		sync_phase(1'b0);
		h_inv = 1'b1;
		v_inv = 1'b0;
		sync_phase(1'b0);
		host_write(`CMD_CFG, 16'h0001 << `CFG_CSYNC_BIT, 16'h0, 1);
		sync_phase(1'b1);
	endtask

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		resetd = 1'b1;
		io_clk = 1'b0;
		io_uio = 1'b0;
		io_din = '0;
		btn_user_n = 1'b1;
		btn_osd_n = 1'b1;
		audio_l_in = '0;
		audio_r_in = '0;
		audio_signed = 1'b0;
		audio_mix = '0;
		hs_in = 1'b0;
		vs_in = 1'b0;
		core_led_user = 1'b1;
		core_led_power = 2'b10;
		core_led_disk = 2'b01;
		lfsr = 32'h8338;
		sync_en = 1'b0;
		h_inv = 1'b0;
		v_inv = 1'b0;
		h_cnt = 0;
		v_cnt = 0;
		h_d1 = 1'b0;
		h_d2 = 1'b0;
		v_d1 = 1'b0;
		v_d2 = 1'b0;
		repeat (4) tick();
		resetd = 1'b0;
		tick();

		test_reset();
		test_led();
		test_audio();
		test_buttons();
		test_sync();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+src
src/sys_ctrl_pkg.sv
src/sys_settings_if.sv
src/host_cmd_decoder.sv
src/button_debounce.sv
src/audio_mixer.sv
src/sync_polarity_fix.sv
src/vga_sync_out.sv
src/led_status.sv
src/sys_ctrl_top.sv
test/tb_sys_ctrl.sv

// File: Makefile
# Verilator build and run of the system control testbench

TOP = tb_sys_ctrl
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f build.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation did not complete"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
